// File: Makefile
TOP = tb_osc_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir

// File: src.f
src/synth_pkg.sv
src/axil_pkg.sv
src/osc_regs.sv
src/osc_saw.sv
src/osc_pulse.sv
src/osc_mixer.sv
src/osc_top.sv
tb/tb_clk.sv
tb/osc_chk.sv
tb/tb_osc_top.sv

// File: src/axil_pkg.sv
/*
  AXI4-Lite channel bundles and the control register map.
  Only an 8-bit address and a 32-bit data bus are supported. There is no AxPROT.
*/

package axil_pkg;

  localparam int AXIL_STRB_W = 4;

  typedef logic [7:0]             axil_addr_t;
  typedef logic [31:0]            axil_data_t;
  typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
  typedef logic [1:0]             axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'd0;
  localparam axil_resp_t RESP_SLVERR = 2'd2;

  // Master to slave signals of all five channels
  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  // Slave to master signals of all five channels
  typedef struct packed {
    logic       awready;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
  } axil_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // Register map

  localparam axil_addr_t ADDR_CTRL         = 8'h00;
  localparam axil_addr_t ADDR_SAW_FREQ     = 8'h04;
  localparam axil_addr_t ADDR_PULSE_PERIOD = 8'h08;
  localparam axil_addr_t ADDR_PULSE_DUTY   = 8'h0C;
  localparam axil_addr_t ADDR_GAIN         = 8'h10;

endpackage

// File: src/osc_mixer.sv
/*
  Two-input weighted mixer with saturation.
  Each gain is applied as gain / 128, so a gain of 255 almost doubles its input.
  The output is one register after the inputs and reads 0 while disabled.
*/

`timescale 1ns/100ps

module osc_mixer
  import synth_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  osc_cfg_t cfg,
  input  sample_t  saw_sample,
  input  sample_t  pulse_sample,
  output sample_t  sample
);

  logic signed [PROD_W-1:0] saw_prod;
  logic signed [PROD_W-1:0] pulse_prod;
  logic signed [SUM_W-1:0]  sum;
  logic signed [SUM_W-1:0]  scaled;
  sample_t                  clamped;

  //////////////////////////////////////////////////////////////////////
  // Weighting and sum

  always_comb begin
    // Gains are zero-extended to keep them positive in the signed product
    saw_prod   = saw_sample * $signed({1'b0, cfg.saw_gain});
    pulse_prod = pulse_sample * $signed({1'b0, cfg.pulse_gain});
    sum        = saw_prod + pulse_prod;
    // Arithmetic shift rounds toward minus infinity
    scaled     = sum >>> GAIN_SHIFT;

    if (scaled > SAMPLE_MAX) begin
      clamped = SAMPLE_MAX;
    end else if (scaled < SAMPLE_MIN) begin
      clamped = SAMPLE_MIN;
    end else begin
      clamped = sample_t'(scaled);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output register

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample <= '0;
    end else if (!cfg.enable) begin
      sample <= '0;
    end else begin
      sample <= clamped;
    end
  end

endmodule

// File: src/osc_pulse.sv
/*
  Pulse oscillator with a period and a high time counted in clocks.
  Period and duty are sampled only at the reload, so a change takes effect at the next cycle.
  Periods of 0 and 1 are not supported. A duty at or above the period keeps the output high.
*/

`timescale 1ns/100ps

module osc_pulse
  import synth_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  osc_cfg_t cfg,
  output sample_t  pulse_sample
);

  typedef enum logic {
    RELOAD,
    COUNTING
  } pulse_state_e;

  pulse_state_e state;
  period_t      cnt;
  period_t      cnt_inc;
  period_t      period_q;
  period_t      duty_q;

  assign cnt_inc = cnt + 1'b1;

  // One pulse cycle is the reload clock plus counter values 0 to period minus 2
  // The output register runs one clock behind and sees the reload as the last position
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= RELOAD;
      cnt          <= '0;
      period_q     <= '0;
      duty_q       <= '0;
      pulse_sample <= SAMPLE_MIN;
    end else if (!cfg.enable) begin
      state        <= RELOAD;
      cnt          <= '0;
      period_q     <= '0;
      duty_q       <= '0;
      pulse_sample <= SAMPLE_MIN;
    end else begin
      case (state)
        RELOAD: begin
          period_q     <= cfg.pulse_period;
          duty_q       <= cfg.pulse_duty;
          cnt          <= '0;
          state        <= COUNTING;
          // First position of the new cycle uses the freshly latched duty
          pulse_sample <= (cfg.pulse_duty != '0) ? SAMPLE_MAX : SAMPLE_MIN;
        end
        COUNTING: begin
          cnt          <= cnt_inc;
          pulse_sample <= (cnt_inc < duty_q) ? SAMPLE_MAX : SAMPLE_MIN;
          if (cnt == period_q - 2'd2) begin
            state <= RELOAD;
          end
        end
        default: begin
          state <= RELOAD;
        end
      endcase
    end
  end

endmodule

// File: src/osc_regs.sv
/*
  AXI4-Lite slave for the oscillator control registers.
  Only one write and one read can be outstanding, and each blocks until B or R is taken.
  AW and W must be presented together. A lone AW or W waits for its partner.
  Only the five aligned addresses of the map are decoded. Others get SLVERR.
*/

`timescale 1ns/100ps

module osc_regs
  import synth_pkg::*;
  import axil_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  output osc_cfg_t  cfg
);

  typedef enum logic {
    W_IDLE,
    W_RESP
  } wr_state_e;

  typedef enum logic {
    R_IDLE,
    R_RESP
  } rd_state_e;

  wr_state_e  wr_state;
  rd_state_e  rd_state;
  osc_cfg_t   cfg_q;

  logic       aw_hs;
  logic       ar_hs;
  axil_data_t wr_merged;
  axil_resp_t bresp_q;
  axil_resp_t rresp_q;
  axil_data_t rdata_q;

  //////////////////////////////////////////////////////////////////////
  // Address decode helpers

  // True for the five addresses that hold a register
  function automatic logic reg_mapped(input axil_addr_t addr);
    case (addr)
      ADDR_CTRL, ADDR_SAW_FREQ, ADDR_PULSE_PERIOD, ADDR_PULSE_DUTY, ADDR_GAIN: begin
        return 1'b1;
      end
      default: begin
        return 1'b0;
      end
    endcase
  endfunction

  // 32-bit image of a register with unused bits at 0
  function automatic axil_data_t reg_image(input axil_addr_t addr, input osc_cfg_t c);
    case (addr)
      ADDR_CTRL:         return axil_data_t'(c.enable);
      ADDR_SAW_FREQ:     return axil_data_t'(c.saw_freq);
      ADDR_PULSE_PERIOD: return axil_data_t'(c.pulse_period);
      ADDR_PULSE_DUTY:   return axil_data_t'(c.pulse_duty);
      ADDR_GAIN:         return axil_data_t'({c.pulse_gain, c.saw_gain});
      default:           return '0;
    endcase
  endfunction

  // Replace only the bytes whose strobe is set
  function automatic axil_data_t strb_merge(input axil_data_t old_data,
                                            input axil_data_t new_data,
                                            input axil_strb_t strb);
    axil_data_t merged;
    merged = old_data;
    for (int i = 0; i < AXIL_STRB_W; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_data[8*i +: 8];
      end
    end
    return merged;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Write channel

  // AW and W are accepted together and only while no B response is waiting
  assign aw_hs     = (wr_state == W_IDLE) && axil_req.awvalid && axil_req.wvalid;
  assign wr_merged = strb_merge(reg_image(axil_req.awaddr, cfg_q), axil_req.wdata,
                                axil_req.wstrb);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_state <= W_IDLE;
    end else begin
      case (wr_state)
        W_IDLE: begin
          if (aw_hs) begin
            wr_state <= W_RESP;
          end
        end
        W_RESP: begin
          if (axil_req.bready) begin
            wr_state <= W_IDLE;
          end
        end
        default: begin
          wr_state <= W_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      bresp_q <= reg_mapped(axil_req.awaddr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Register contents change on the handshake edge so cfg follows at once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else if (aw_hs) begin
      case (axil_req.awaddr)
        ADDR_CTRL:         cfg_q.enable       <= wr_merged[0];
        ADDR_SAW_FREQ:     cfg_q.saw_freq     <= wr_merged[PHASE_W-1:0];
        ADDR_PULSE_PERIOD: cfg_q.pulse_period <= wr_merged[PERIOD_W-1:0];
        ADDR_PULSE_DUTY:   cfg_q.pulse_duty   <= wr_merged[PERIOD_W-1:0];
        ADDR_GAIN: begin
          cfg_q.saw_gain   <= wr_merged[GAIN_W-1:0];
          cfg_q.pulse_gain <= wr_merged[2*GAIN_W-1:GAIN_W];
        end
        default: begin
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read channel

  assign ar_hs = (rd_state == R_IDLE) && axil_req.arvalid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_state <= R_IDLE;
    end else begin
      case (rd_state)
        R_IDLE: begin
          if (ar_hs) begin
            rd_state <= R_RESP;
          end
        end
        R_RESP: begin
          if (axil_req.rready) begin
            rd_state <= R_IDLE;
          end
        end
        default: begin
          rd_state <= R_IDLE;
        end
      endcase
    end
  end

  // Unmapped reads return 0 through the default of reg_image
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata_q <= reg_image(axil_req.araddr, cfg_q);
      rresp_q <= reg_mapped(axil_req.araddr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_comb begin
    axil_rsp.awready = aw_hs;
    axil_rsp.wready  = aw_hs;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.bvalid  = (wr_state == W_RESP);
    axil_rsp.arready = ar_hs;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
    axil_rsp.rvalid  = (rd_state == R_RESP);
  end

  assign cfg = cfg_q;

endmodule

// File: src/osc_saw.sv
/*
  Phase-accumulator sawtooth oscillator.
  The output frequency is saw_freq / 2^24 of the clock rate, and the ramp steps by
  saw_freq / 256 per clock. Small words below 256 move the sample only every few clocks.
*/

`timescale 1ns/100ps

module osc_saw
  import synth_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  osc_cfg_t cfg,
  output sample_t  saw_sample
);

  phase_t phase;

  // The accumulator wraps naturally at 2^24, which gives the sawtooth its fall
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (!cfg.enable) begin
      // Disabled oscillators sit at their reset phase
      phase <= '0;
    end else begin
      phase <= phase + cfg.saw_freq;
    end
  end

  // The phase register is also the output register
  // Inverting the MSB maps phase 0 to SAMPLE_MIN and full scale to SAMPLE_MAX
  assign saw_sample = sample_t'({~phase[PHASE_W-1], phase[PHASE_W-2 -: SAMPLE_W-1]});

endmodule

// File: src/osc_top.sv
/*
  Tone generator top with an AXI4-Lite control port and one signed sample per clock.
  The audio output has no valid or ready. A new sample appears on every clock edge.
  Latency from oscillator state to sample is two clocks.
*/

`timescale 1ns/100ps

module osc_top
  import synth_pkg::*;
  import axil_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  output sample_t   sample
);

  osc_cfg_t cfg;
  sample_t  saw_sample;
  sample_t  pulse_sample;

  //////////////////////////////////////////////////////////////////////
  // Control

  // Register block drives the same configuration to every datapath block
  osc_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .cfg      (cfg)
  );

  //////////////////////////////////////////////////////////////////////
  // Datapath

  osc_saw u_saw (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .saw_sample (saw_sample)
  );

  osc_pulse u_pulse (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .pulse_sample (pulse_sample)
  );

  // Both oscillators are registered, so the mixer sees aligned samples
  osc_mixer u_mixer (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .saw_sample   (saw_sample),
    .pulse_sample (pulse_sample),
    .sample       (sample)
  );

endmodule

// File: src/synth_pkg.sv
/*
  Sample, phase, period and gain types shared by the tone generator datapath.
  Samples are signed 16-bit two's complement and gains are unsigned with 128 as unity.
  Phase and period words are 24 bits wide. Larger values need wider register fields.
*/

package synth_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths

  localparam int SAMPLE_W = 16;
  localparam int PHASE_W  = 24;
  localparam int PERIOD_W = 24;
  localparam int GAIN_W   = 8;

  // A sample times a zero-extended gain needs one extra bit for the sign
  localparam int PROD_W = SAMPLE_W + GAIN_W + 1;
  // The sum of two products can grow by one more bit
  localparam int SUM_W  = PROD_W + 1;

  //////////////////////////////////////////////////////////////////////
  // Types

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic        [PHASE_W-1:0]  phase_t;
  typedef logic        [PERIOD_W-1:0] period_t;
  typedef logic        [GAIN_W-1:0]   gain_t;

  //////////////////////////////////////////////////////////////////////
  // Mixer constants

  localparam sample_t SAMPLE_MAX = 16'sh7FFF;
  localparam sample_t SAMPLE_MIN = 16'sh8000;
  // A gain of 128 shifted right by 7 gives unity
  localparam int      GAIN_SHIFT = 7;

  // Complete oscillator configuration as seen by the datapath
  typedef struct packed {
    logic    enable;
    phase_t  saw_freq;
    period_t pulse_period;
    period_t pulse_duty;
    gain_t   saw_gain;
    gain_t   pulse_gain;
  } osc_cfg_t;

endpackage

// File: tb/osc_chk.sv
/*
  Concurrent checks on the AXI4-Lite response channels and on the disabled output.
  Bound into osc_top and idle while rst_n is low.
*/

`timescale 1ns/100ps

module osc_chk
  import synth_pkg::*;
  import axil_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input axil_req_t axil_req,
  input axil_rsp_t axil_rsp,
  input sample_t   sample,
  input logic      enable
);

  // A pending B response keeps valid and its code until the master takes it
  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
    else $error("B channel: bvalid or bresp changed while bready was low");

  // Same rule on R, with the read data held as well
  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.rvalid && !axil_req.rready |=>
      axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
    else $error("R channel: rvalid, rdata or rresp changed while rready was low");

  // Every B response follows an AW and W handshake on the cycle before
  b_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(axil_rsp.bvalid) |-> $past(axil_rsp.awready && axil_rsp.wready))
    else $error("B channel: bvalid rose without a write handshake");

  // Two disabled cycles in a row leave the mixer output at 0
  quiet: assert property (@(posedge clk) disable iff (!rst_n)
    $past(!enable) && !enable |=> sample == '0)
    else $error("Output: sample is not 0 while the generator is disabled");

endmodule

// File: tb/tb_clk.sv
/*
  Free-running 10 ns clock and an active-low reset held for 8 rising edges.
  Reset is released on a rising edge, so every flop still sees it on that edge.
*/

`timescale 1ns/100ps

module tb_clk (
  output logic clk,
  output logic rst_n
);

  localparam int RESET_CYCLES = 8;

  // Half period of 5 ns gives the 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: tb/tb_osc_top.sv
/*
  Table-driven testbench for the tone generator, acting as AXI4-Lite master.
  Registers persist from row to row, so the register rows depend on their order.
  Each datapath row reprograms every register with enable low, then enables.
  Outputs are sampled on the falling edge, inputs change on the rising edge.
*/

`timescale 1ns/100ps

module tb_osc_top
  import synth_pkg::*;
  import axil_pkg::*;
();

  typedef enum {K_REG, K_SAW, K_PULSE, K_MIX, K_ENABLE} kind_e;

  typedef struct {
    kind_e      kind;
    axil_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
    axil_resp_t exp_resp;
    axil_data_t exp_data;
    phase_t     freq;
    period_t    period;
    period_t    duty;
    gain_t      saw_gain;
    gain_t      pulse_gain;
    sample_t    exp_sample;
    int         window;
  } test_row_t;

  localparam int N_ROWS       = 18;
  // Bus traffic and settling per row, in clocks
  localparam int ROW_OVERHEAD = 80;
  localparam int MARGIN       = 200;
  // Covers the two register stages between cfg and sample
  localparam int SETTLE       = 6;
  localparam int QUIET_CYCLES = 20;

  logic      clk;
  logic      rst_n;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  sample_t   sample;
  test_row_t tbl [N_ROWS];
  int        seed;
  int        cycles;
  int        cycle_limit;
  int        errors;

  tb_clk u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  osc_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .sample   (sample)
  );

  bind osc_top osc_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .sample   (sample),
    .enable   (cfg.enable)
  );

  // The run limit is set at time 0 from the table before the first clock edge
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: no result after %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Table helpers

  // Implemented bits of each register in the map
  function automatic axil_data_t width_mask(input axil_addr_t addr);
    case (addr)
      ADDR_CTRL:                                         return 32'h0000_0001;
      ADDR_SAW_FREQ, ADDR_PULSE_PERIOD, ADDR_PULSE_DUTY: return 32'h00FF_FFFF;
      ADDR_GAIN:                                         return 32'h0000_FFFF;
      default:                                           return 32'h0000_0000;
    endcase
  endfunction

  function automatic test_row_t reg_row(input axil_addr_t addr, input axil_data_t data,
                                        input axil_strb_t strb, input axil_resp_t resp,
                                        input axil_data_t exp_data);
    test_row_t r;
    r.kind       = K_REG;
    r.addr       = addr;
    r.data       = data;
    r.strb       = strb;
    r.exp_resp   = resp;
    r.exp_data   = exp_data;
    r.freq       = '0;
    r.period     = '0;
    r.duty       = '0;
    r.saw_gain   = '0;
    r.pulse_gain = '0;
    r.exp_sample = '0;
    r.window     = 0;
    return r;
  endfunction

  function automatic test_row_t dp_row(input kind_e kind, input phase_t freq,
                                       input period_t period, input period_t duty,
                                       input gain_t sg, input gain_t pg,
                                       input sample_t exp_sample, input int window);
    test_row_t r;
    r            = reg_row(ADDR_CTRL, '0, '0, RESP_OKAY, '0);
    r.kind       = kind;
    r.freq       = freq;
    r.period     = period;
    r.duty       = duty;
    r.saw_gain   = sg;
    r.pulse_gain = pg;
    r.exp_sample = exp_sample;
    r.window     = window;
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus master

  task automatic report_mismatch(input string name, input longint got, input longint expected);
    $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, expected);
    errors++;
  endtask

  task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
                           input axil_strb_t strb, output axil_resp_t resp);
    @(posedge clk);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= strb;
    axil_req.wvalid  <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.awready) begin
      @(negedge clk);
    end
    // The handshake completes on this edge
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.bvalid) begin
      @(negedge clk);
    end
    // The B response waits one clock with bready low before it is taken
    @(posedge clk);
    axil_req.bready <= 1'b1;
    @(negedge clk);
    resp = axil_rsp.bresp;
    @(posedge clk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axi_read(input axil_addr_t addr, output axil_data_t data,
                          output axil_resp_t resp);
    @(posedge clk);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.arready) begin
      @(negedge clk);
    end
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.rvalid) begin
      @(negedge clk);
    end
    // Read data also waits one clock with rready low
    @(posedge clk);
    axil_req.rready <= 1'b1;
    @(negedge clk);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clk);
    axil_req.rready <= 1'b0;
  endtask

  task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
    axil_resp_t resp;
    axi_write(addr, data, 4'hF, resp);
    if (resp !== RESP_OKAY) begin
      report_mismatch("bresp", resp, RESP_OKAY);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Row checks

  // Enable goes low first so both oscillators restart from reset state
  task automatic program_osc(input test_row_t r);
    write_reg(ADDR_CTRL, 32'h0);
    write_reg(ADDR_SAW_FREQ, axil_data_t'(r.freq));
    write_reg(ADDR_PULSE_PERIOD, axil_data_t'(r.period));
    write_reg(ADDR_PULSE_DUTY, axil_data_t'(r.duty));
    write_reg(ADDR_GAIN, {16'h0000, r.pulse_gain, r.saw_gain});
    write_reg(ADDR_CTRL, 32'h1);
    repeat (SETTLE) @(negedge clk);
  endtask

  task automatic check_register(input test_row_t r);
    axil_data_t rdata;
    axil_resp_t resp;
    axi_write(r.addr, r.data, r.strb, resp);
    if (resp !== r.exp_resp) begin
      report_mismatch("bresp", resp, r.exp_resp);
    end
    axi_read(r.addr, rdata, resp);
    if (resp !== r.exp_resp) begin
      report_mismatch("rresp", resp, r.exp_resp);
    end
    if (rdata !== r.exp_data) begin
      report_mismatch("rdata", rdata, r.exp_data);
    end
  endtask

  // Unity saw gain passes the ramp straight through, so steps are freq / 256
  task automatic check_saw(input test_row_t r);
    int step;
    int last;
    int cur;
    step = int'(r.freq) / 256;
    last = int'(sample);
    for (int i = 0; i < r.window; i++) begin
      @(negedge clk);
      cur = int'(sample);
      if (cur - last != step) begin
        if (!(last > SAMPLE_MAX - step && cur < SAMPLE_MIN + step)) begin
          report_mismatch("sample step", cur - last, step);
        end
      end
      last = cur;
    end
  endtask

  // The first run is partial and the last one never closes, so neither is checked
  task automatic check_runs(input test_row_t r);
    int level;
    int run;
    int idx;
    int checked;
    int want;
    level   = int'(sample);
    run     = 1;
    idx     = 0;
    checked = 0;
    for (int i = 0; i < r.window; i++) begin
      @(negedge clk);
      if (sample !== SAMPLE_MAX && sample !== SAMPLE_MIN) begin
        report_mismatch("sample level", sample, SAMPLE_MIN);
      end
      if (int'(sample) == level) begin
        run++;
      end else begin
        if (idx > 0) begin
          want = (level == SAMPLE_MAX) ? int'(r.duty) : int'(r.period) - int'(r.duty);
          if (run != want) begin
            report_mismatch("run length", run, want);
          end
          checked++;
        end
        idx++;
        level = int'(sample);
        run   = 1;
      end
    end
    if (checked < 4) begin
      $display("Pulse check found only %0d complete runs in %0d cycles", checked, r.window);
      errors++;
    end
  endtask

  task automatic check_constant(input sample_t expected, input int window);
    for (int i = 0; i < window; i++) begin
      @(negedge clk);
      if (sample !== expected) begin
        report_mismatch("sample", sample, expected);
      end
    end
  endtask

  task automatic run_row(input test_row_t r);
    case (r.kind)
      K_REG: begin
        check_register(r);
      end
      K_SAW: begin
        program_osc(r);
        check_saw(r);
      end
      K_PULSE: begin
        program_osc(r);
        if (r.duty >= r.period) begin
          check_constant(SAMPLE_MAX, r.window);
        end else begin
          check_runs(r);
        end
      end
      K_MIX: begin
        program_osc(r);
        check_constant(r.exp_sample, r.window);
      end
      default: begin
        // Disable, expect silence, then the same pulse train again
        program_osc(r);
        check_runs(r);
        write_reg(ADDR_CTRL, 32'h0);
        repeat (SETTLE) @(negedge clk);
        check_constant('0, QUIET_CYCLES);
        write_reg(ADDR_CTRL, 32'h1);
        repeat (SETTLE) @(negedge clk);
        check_runs(r);
      end
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test table and main sequence

  initial begin
    axil_data_t rnd;
    int         total;
    int         start;
    int         passed;
    int         failed;
    axil_req    = '0;
    seed        = 1;
    cycles      = 0;
    errors      = 0;
    passed      = 0;
    failed      = 0;
    rnd         = $random(seed);

    tbl[0]  = reg_row(ADDR_CTRL, 32'hFFFF_FFFF, 4'hF, RESP_OKAY, 32'h0000_0001);
    tbl[1]  = reg_row(ADDR_SAW_FREQ, 32'h12A1_B2C3, 4'hF, RESP_OKAY, 32'h00A1_B2C3);
    tbl[2]  = reg_row(ADDR_SAW_FREQ, 32'hFFFF_FFFF, 4'h2, RESP_OKAY, 32'h00A1_FFC3);
    tbl[3]  = reg_row(ADDR_PULSE_PERIOD, 32'hDEAD_BEEF, 4'hF, RESP_OKAY, 32'h00AD_BEEF);
    tbl[4]  = reg_row(ADDR_PULSE_DUTY, 32'h0F0F_0F0F, 4'hC, RESP_OKAY, 32'h000F_0000);
    tbl[5]  = reg_row(ADDR_GAIN, 32'h89AB_CDEF, 4'hF, RESP_OKAY, 32'h0000_CDEF);
    tbl[6]  = reg_row(8'h14, 32'h0000_0001, 4'hF, RESP_SLVERR, 32'h0000_0000);
    tbl[7]  = reg_row(ADDR_GAIN, rnd, 4'hF, RESP_OKAY, rnd & width_mask(ADDR_GAIN));
    tbl[8]  = dp_row(K_SAW, 24'h04_0000, 24'd10, 24'd3, 8'd128, 8'd0, 16'sd0, 200);
    tbl[9]  = dp_row(K_PULSE, 24'h0, 24'd10, 24'd3, 8'd0, 8'd128, 16'sd0, 80);
    tbl[10] = dp_row(K_PULSE, 24'h0, 24'd7, 24'd12, 8'd0, 8'd128, 16'sd0, 40);
    // Saw sits at -32768 and the pulse at +32767 or -32768
    tbl[11] = dp_row(K_MIX, 24'h0, 24'd10, 24'd20, 8'd0, 8'd128, 16'sd32767, 20);
    tbl[12] = dp_row(K_MIX, 24'h0, 24'd10, 24'd0, 8'd64, 8'd0, -16'sd16384, 20);
    tbl[13] = dp_row(K_MIX, 24'h0, 24'd10, 24'd20, 8'd0, 8'd64, 16'sd16383, 20);
    tbl[14] = dp_row(K_MIX, 24'h0, 24'd10, 24'd20, 8'd128, 8'd255, 16'sd32510, 20);
    tbl[15] = dp_row(K_MIX, 24'h0, 24'd10, 24'd20, 8'd0, 8'd255, 16'sd32767, 20);
    tbl[16] = dp_row(K_MIX, 24'h0, 24'd10, 24'd0, 8'd255, 8'd255, -16'sd32768, 20);
    tbl[17] = dp_row(K_ENABLE, 24'h0, 24'd8, 24'd5, 8'd0, 8'd128, 16'sd0, 60);

    // The enable row observes its window twice, so every window counts double
    total = MARGIN;
    for (int t = 0; t < N_ROWS; t++) begin
      total += 2 * tbl[t].window + ROW_OVERHEAD;
    end
    cycle_limit = total;

    @(posedge rst_n);
    for (int t = 0; t < N_ROWS; t++) begin
      start = errors;
      run_row(tbl[t]);
      if (errors == start) begin
        passed++;
        $display("Test %0d (%s): passed", t, tbl[t].kind.name());
      end else begin
        failed++;
        $display("Test %0d (%s): failed with %0d errors", t, tbl[t].kind.name(),
                 errors - start);
      end
    end

    $display("Summary: %0d tests passed, %0d failed, %0d errors", passed, failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
